/* Bender.yml */
package:
  name: uart_apb_master

sources:
  - hdl/uart_reg_pkg.sv
  - hdl/uart_link_pkg.sv
  - hdl/apb_reg_file.sv
  - hdl/line_error_flags.sv
  - hdl/tx_word_unpacker.sv
  - hdl/rx_word_packer.sv
  - hdl/uart_apb_master.sv
  - target: test
    files:
      - bench/uart_apb_assertions.sv
      - bench/tb_uart_apb_master.sv

/* bench/tb_uart_apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_apb_master;

    localparam int unsigned max_cycles = 3000;

    logic                        clk;
    logic                        resetn;
    uart_reg_pkg::bus_word_t     paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    uart_reg_pkg::bus_word_t     pwdata;
    uart_reg_pkg::bus_strb_t     pstrb;
    wire                         pready;
    uart_reg_pkg::bus_word_t     prdata;
    wire                         pslverr;
    uart_link_pkg::uart_byte_t   tx_data;
    wire                         tx_fifo_write_en;
    uart_link_pkg::uart_byte_t   rx_data;
    wire                         rx_fifo_read_en;
    uart_link_pkg::fifo_status_t fifo_status;
    uart_link_pkg::line_err_t    line_err;
    uart_link_pkg::line_cfg_t    line_cfg;
    wire                         interrupt;

    logic tx_room;
    logic tx_room_level; // Level used when not stalling
    logic tx_stall;
    logic rx_has_data;
    logic rx_room;
    logic tx_done_lvl;

    uart_link_pkg::uart_byte_t tx_pushed[$];
    uart_link_pkg::uart_byte_t tx_expected[$];
    uart_link_pkg::uart_byte_t rx_queue[$];

    int          errors = 0;
    int          tests_run = 0;
    int unsigned cycles = 0;

    assign fifo_status = '{tx_done: tx_done_lvl, tx_notfull: tx_room,
                           rx_notfull: rx_room, rx_notempty: rx_has_data};

    uart_apb_master i_dut (
        .clk(clk), .resetn(resetn),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .tx_data(tx_data), .tx_fifo_write_en(tx_fifo_write_en),
        .rx_data(rx_data), .rx_fifo_read_en(rx_fifo_read_en),
        .fifo_status(fifo_status), .line_err(line_err),
        .line_cfg(line_cfg), .interrupt(interrupt)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // TX FIFO model
    always @(negedge clk) begin
        if (tx_stall)
            tx_room = ($urandom % 3) != 0;
        else
            tx_room = tx_room_level;
    end

    always @(posedge clk) begin
        if (resetn && tx_fifo_write_en)
            tx_pushed.push_back(tx_data);
    end

    // RX FIFO model, head byte shown from the falling edge
    always @(posedge clk) begin
        if (resetn && rx_fifo_read_en && rx_queue.size() > 0)
            void'(rx_queue.pop_front());
    end

    always @(negedge clk) begin
        rx_has_data = rx_queue.size() != 0;
        rx_data     = rx_has_data ? rx_queue[0] : 8'h00;
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [35:0] exp, input logic [35:0] act);
        $display("** Error [%s] %s: expected %0h, actual %0h", test, what, exp, act);
        errors++;
    endtask

    task automatic apb_access(input logic wr, input uart_reg_pkg::bus_word_t addr,
                              input uart_reg_pkg::bus_word_t wdata,
                              input uart_reg_pkg::bus_strb_t strb,
                              output uart_reg_pkg::bus_word_t rdata,
                              output logic err, output int waits);
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = wr ? strb : 4'h0;
        @(negedge clk);
        penable = 1'b1;
        #10;
        while (!pready) begin
            waits++;
            @(negedge clk);
            #10;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input uart_reg_pkg::bus_word_t addr,
                             input uart_reg_pkg::bus_word_t data,
                             input uart_reg_pkg::bus_strb_t strb,
                             output logic err, output int waits);
        uart_reg_pkg::bus_word_t unused;
        apb_access(1'b1, addr, data, strb, unused, err, waits);
    endtask

    task automatic apb_read(input uart_reg_pkg::bus_word_t addr,
                            output uart_reg_pkg::bus_word_t data, output logic err);
        int waits;
        apb_access(1'b0, addr, '0, 4'h0, data, err, waits);
    endtask

    function automatic uart_reg_pkg::bus_word_t lane_mask(input uart_reg_pkg::bus_strb_t strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic check_strobed_write(input uart_reg_pkg::bus_word_t off,
                                       inout uart_reg_pkg::bus_word_t model);
        uart_reg_pkg::bus_word_t val;
        uart_reg_pkg::bus_word_t mask;
        uart_reg_pkg::bus_word_t rd;
        uart_reg_pkg::bus_strb_t strb;
        logic err;
        int waits;
        val  = $urandom;
        strb = 4'($urandom);
        mask = lane_mask(strb);
        apb_write(off, val, strb, err, waits);
        model = (model & ~mask) | (val & mask);
        apb_read(off, rd, err);
        if (rd !== model)
            report_mismatch("registers", $sformatf("readback at %0h", off), model, rd);
    endtask

    task automatic test_registers();
        uart_reg_pkg::bus_word_t rd;
        uart_reg_pkg::bus_word_t baud_exp;
        uart_reg_pkg::bus_word_t ctrl_exp;
        uart_reg_pkg::bus_word_t int_exp;
        logic err;
        int waits;
        tests_run++;
        baud_exp = 32'h0000_0A2C;
        ctrl_exp = 32'h0;
        int_exp  = 32'h0;
        apb_read(uart_reg_pkg::baud_off, rd, err);
        if (rd !== baud_exp) report_mismatch("registers", "baud reset", baud_exp, rd);
        apb_read(uart_reg_pkg::control_off, rd, err);
        if (rd !== ctrl_exp) report_mismatch("registers", "control reset", ctrl_exp, rd);
        apb_read(uart_reg_pkg::int_en_off, rd, err);
        if (rd !== int_exp) report_mismatch("registers", "int_en reset", int_exp, rd);
        repeat (4) begin
            check_strobed_write(uart_reg_pkg::baud_off, baud_exp);
            check_strobed_write(uart_reg_pkg::control_off, ctrl_exp);
            check_strobed_write(uart_reg_pkg::int_en_off, int_exp);
            if (line_cfg.baud !== baud_exp)
                report_mismatch("registers", "line_cfg baud", baud_exp, line_cfg.baud);
            if ({line_cfg.stop_bits, line_cfg.parity_mode} !== ctrl_exp[3:0])
                report_mismatch("registers", "line_cfg mode", ctrl_exp[3:0],
                                {line_cfg.stop_bits, line_cfg.parity_mode});
        end
        apb_write(uart_reg_pkg::int_en_off, 32'h0, 4'hF, err, waits);
    endtask

    task automatic check_slverr(input logic wr, input uart_reg_pkg::bus_word_t addr,
                                input logic exp);
        uart_reg_pkg::bus_word_t rd;
        logic err;
        int waits;
        apb_access(wr, addr, 32'h0, 4'hF, rd, err, waits);
        if (err !== exp)
            report_mismatch("slave_errors", $sformatf("pslverr %s %0h", wr ? "write" : "read",
                            addr), exp, err);
    endtask

    task automatic test_slave_errors();
        tests_run++;
        check_slverr(1'b0, 32'h1C, 1'b1); // Unmapped
        check_slverr(1'b1, 32'h40, 1'b1);
        check_slverr(1'b0, 32'h02, 1'b1);
        check_slverr(1'b0, 32'h00, 1'b1);
        check_slverr(1'b0, 32'h14, 1'b1);
        check_slverr(1'b1, 32'h04, 1'b1);
        check_slverr(1'b1, 32'h0C, 1'b1);
        check_slverr(1'b0, 32'h04, 1'b0);
        check_slverr(1'b0, 32'h08, 1'b0);
        check_slverr(1'b0, 32'h0C, 1'b0);
        check_slverr(1'b1, 32'h10, 1'b0);
        check_slverr(1'b1, 32'h14, 1'b0);
        check_slverr(1'b0, 32'h18, 1'b0);
    endtask

    task automatic send_tx_word(input uart_reg_pkg::bus_word_t word,
                                input uart_reg_pkg::bus_strb_t strb, output int waits);
        logic err;
        apb_write(uart_reg_pkg::tx_data_off, word, strb, err, waits);
        if (err !== 1'b0) report_mismatch("tx_unpack", "pslverr on TX write", 0, err);
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                tx_expected.push_back(word[8*i +: 8]);
        end
    endtask

    task automatic wait_tx_idle();
        @(negedge clk);
        while (i_dut.tx_req || i_dut.tx_ack)
            @(negedge clk);
    endtask

    task automatic compare_tx();
        if (tx_pushed.size() != tx_expected.size()) begin
            report_mismatch("tx_unpack", "byte count", tx_expected.size(), tx_pushed.size());
        end else begin
            for (int i = 0; i < tx_expected.size(); i++) begin
                if (tx_pushed[i] !== tx_expected[i])
                    report_mismatch("tx_unpack", $sformatf("byte %0d", i), tx_expected[i],
                                    tx_pushed[i]);
            end
        end
        tx_pushed.delete();
        tx_expected.delete();
    endtask

    task automatic test_tx();
        uart_reg_pkg::bus_strb_t strb;
        int waits;
        tests_run++;
        for (int n = 0; n < 16; n++) begin
            tx_stall = (n >= 8); // Second half with random back-pressure
            strb = (n == 3) ? 4'h0 : 4'($urandom);
            send_tx_word($urandom, strb, waits);
            wait_tx_idle();
        end
        tx_stall = 1'b0;
        compare_tx();
        send_tx_word($urandom, 4'hF, waits);
        send_tx_word($urandom, 4'hF, waits);
        if (waits == 0) begin
            $display("Error [tx_unpack]: second TX write did not wait for pready");
            errors++;
        end
        wait_tx_idle();
        compare_tx();
    endtask

    task automatic test_rx();
        uart_reg_pkg::bus_word_t exp;
        uart_reg_pkg::bus_word_t rd;
        uart_link_pkg::uart_byte_t b;
        logic err;
        tests_run++;
        for (int n = 1; n <= 4; n++) begin
            exp = '0;
            for (int k = 0; k < n; k++) begin
                b = 8'($urandom);
                rx_queue.push_back(b);
                exp[8*k +: 8] = b;
            end
            @(negedge clk);
            while (rx_queue.size() != 0)
                @(negedge clk);
            repeat (2) @(negedge clk);
            apb_read(uart_reg_pkg::rx_data_off, rd, err);
            if (rd !== exp)
                report_mismatch("rx_pack", $sformatf("word of %0d bytes", n), exp, rd);
        end
    endtask

    task automatic test_line_errors();
        uart_reg_pkg::bus_word_t rd;
        logic [3:0] sticky;
        logic err;
        int waits;
        tests_run++;
        sticky = 4'h0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            line_err = uart_link_pkg::line_err_t'(4'b0001 << i);
            @(negedge clk);
            line_err = '0;
            sticky[i] = 1'b1;
            apb_read(uart_reg_pkg::status_off, rd, err);
            if (rd[7:4] !== sticky) report_mismatch("line_errors", "sticky flags", sticky, rd[7:4]);
        end
        for (int i = 0; i < 4; i++) begin
            apb_write(uart_reg_pkg::int_en_off, 32'h1 << (4 + i), 4'hF, err, waits);
            if (interrupt !== 1'b1)
                report_mismatch("line_errors", $sformatf("interrupt on bit %0d", 4 + i), 1, interrupt);
            apb_write(uart_reg_pkg::status_clear_off, 32'h1 << i, 4'h1, err, waits);
            sticky[i] = 1'b0;
            apb_read(uart_reg_pkg::status_off, rd, err);
            if (rd[7:4] !== sticky) report_mismatch("line_errors", "flags after clear", sticky, rd[7:4]);
            if (interrupt !== 1'b0)
                report_mismatch("line_errors", $sformatf("interrupt after clear %0d", i), 0, interrupt);
        end
        apb_write(uart_reg_pkg::int_en_off, 32'h0, 4'hF, err, waits);
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            rx_room       = n[0];
            tx_room_level = n[1];
            tx_done_lvl   = n[2];
            apb_read(uart_reg_pkg::status_off, rd, err);
            if (rd[3:0] !== {n[2], n[1], n[0], 1'b0}) // RX queue empty here
                report_mismatch("line_errors", "live FIFO status", {n[2], n[1], n[0], 1'b0}, rd[3:0]);
        end
        tx_room_level = 1'b1;
        rx_room       = 1'b1;
        tx_done_lvl   = 1'b0;
    endtask

    initial begin
        void'($urandom(46));
        clk           = 1'b0;
        resetn        = 1'b0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        pstrb         = '0;
        rx_data       = '0;
        line_err      = '0;
        tx_room       = 1'b1;
        tx_room_level = 1'b1;
        tx_stall      = 1'b0;
        rx_has_data   = 1'b0;
        rx_room       = 1'b1;
        tx_done_lvl   = 1'b0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        test_registers();
        test_slave_errors();
        test_tx();
        test_rx();
        test_line_errors();
        repeat (2) @(negedge clk);
        errors += i_dut.i_assertions.fail_count;
        $display("Tests run: %0d, errors: %0d (assertion failures: %0d)", tests_run, errors,
                 i_dut.i_assertions.fail_count);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/uart_apb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_apb_assertions (
    input wire                              clk,
    input wire                              resetn,
    input wire                              psel,
    input wire                              penable,
    input wire                              pready,
    input wire                              pslverr,
    input wire                              tx_fifo_write_en,
    input wire                              rx_fifo_read_en,
    input wire uart_link_pkg::fifo_status_t fifo_status,
    input wire uart_reg_pkg::bus_word_t     int_en,
    input wire                              interrupt
);

    int fail_count = 0;

    a_tx_room: assert property (@(posedge clk) disable iff (!resetn)
        tx_fifo_write_en |-> fifo_status.tx_notfull)
        else begin
            $error("TX FIFO pushed while full");
            fail_count++;
        end

    a_slverr_in_access: assert property (@(posedge clk) disable iff (!resetn)
        pslverr |-> (psel && penable && pready))
        else begin
            $error("pslverr outside a completing access phase");
            fail_count++;
        end

    a_rx_not_empty: assert property (@(posedge clk) disable iff (!resetn)
        rx_fifo_read_en |-> fifo_status.rx_notempty)
        else begin
            $error("RX FIFO popped while empty");
            fail_count++;
        end

    a_irq_masked: assert property (@(posedge clk) disable iff (!resetn)
        (int_en == '0) |-> !interrupt)
        else begin
            $error("interrupt high with all enables clear");
            fail_count++;
        end

endmodule

bind uart_apb_master uart_apb_assertions i_assertions (
    .clk(clk),
    .resetn(resetn),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .tx_fifo_write_en(tx_fifo_write_en),
    .rx_fifo_read_en(rx_fifo_read_en),
    .fifo_status(fifo_status),
    .int_en(int_en),
    .interrupt(interrupt)
);

`default_nettype wire

/* hdl/apb_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_reg_file #(
    parameter uart_reg_pkg::bus_word_t base_addr = '0
) (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire uart_reg_pkg::bus_word_t  paddr,
    input  wire uart_reg_pkg::bus_word_t  pwdata,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire uart_reg_pkg::bus_strb_t  pstrb,
    output logic                          pready,
    output uart_reg_pkg::bus_word_t       prdata,
    output logic                          pslverr,
    input  wire uart_reg_pkg::bus_word_t  rx_word,
    input  wire uart_link_pkg::fifo_status_t fifo_status,
    input  wire uart_link_pkg::line_err_t err_flags,
    input  wire                           tx_ack,
    output logic                          tx_req,
    output uart_reg_pkg::tx_req_t         tx_req_data,
    output uart_link_pkg::line_cfg_t      line_cfg,
    output uart_reg_pkg::bus_word_t       status_word,
    output logic [3:0]                    clr_pulse,
    output uart_reg_pkg::bus_word_t       int_en
);

    function automatic uart_reg_pkg::bus_word_t strb_merge(
        input uart_reg_pkg::bus_word_t old_val,
        input uart_reg_pkg::bus_word_t new_val,
        input uart_reg_pkg::bus_strb_t strb
    );
        uart_reg_pkg::bus_word_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    logic                    busy;
    logic                    access;
    logic                    wr_en;
    logic                    acc_err;
    uart_reg_pkg::bus_word_t offset;
    uart_reg_pkg::bus_word_t rd_data;
    uart_reg_pkg::bus_word_t baud;
    uart_reg_pkg::bus_word_t control;

    assign busy   = tx_req | tx_ack; // TX handshake in flight
    assign pready = penable & ~busy;
    assign access = psel & penable & pready;
    assign offset = paddr - base_addr;
    assign wr_en  = access & pwrite & ~acc_err;

    always_comb begin
        status_word = '0;
        status_word[uart_reg_pkg::st_rx_notempty] = fifo_status.rx_notempty;
        status_word[uart_reg_pkg::st_rx_notfull]  = fifo_status.rx_notfull;
        status_word[uart_reg_pkg::st_tx_notfull]  = fifo_status.tx_notfull;
        status_word[uart_reg_pkg::st_tx_done]     = fifo_status.tx_done;
        status_word[uart_reg_pkg::st_parity]      = err_flags.parity_err;
        status_word[uart_reg_pkg::st_overrun]     = err_flags.overrun_err;
        status_word[uart_reg_pkg::st_frame]       = err_flags.frame_err;
        status_word[uart_reg_pkg::st_break]       = err_flags.break_err;
    end

    // Address decode, direction check and read select
    always_comb begin
        acc_err = 1'b0;
        rd_data = '0;
        case (offset)
            uart_reg_pkg::tx_data_off:      acc_err = ~pwrite;
            uart_reg_pkg::rx_data_off: begin
                acc_err = pwrite;
                rd_data = rx_word;
            end
            uart_reg_pkg::baud_off:         rd_data = baud;
            uart_reg_pkg::status_off: begin
                acc_err = pwrite;
                rd_data = status_word;
            end
            uart_reg_pkg::control_off:      rd_data = control;
            uart_reg_pkg::status_clear_off: acc_err = ~pwrite;
            uart_reg_pkg::int_en_off:       rd_data = int_en;
            default:                        acc_err = 1'b1; // Unmapped
        endcase
    end

    assign pslverr = access & acc_err;
    assign prdata  = (access && !pwrite) ? rd_data : '0;

    // Clear bits live in lane 0 only
    assign clr_pulse = (wr_en && offset == uart_reg_pkg::status_clear_off && pstrb[0]) ?
                       pwdata[3:0] : 4'd0;

    assign line_cfg = '{baud: baud, parity_mode: control[1:0], stop_bits: control[3:2]};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            baud    <= uart_reg_pkg::baud_reset;
            control <= uart_reg_pkg::control_reset;
            int_en  <= uart_reg_pkg::int_en_reset;
            tx_req  <= 1'b0;
        end else begin
            if (wr_en) begin
                case (offset)
                    uart_reg_pkg::baud_off:    baud    <= strb_merge(baud, pwdata, pstrb);
                    uart_reg_pkg::control_off: control <= strb_merge(control, pwdata, pstrb);
                    uart_reg_pkg::int_en_off:  int_en  <= strb_merge(int_en, pwdata, pstrb);
                    default: ;
                endcase
            end
            if (wr_en && offset == uart_reg_pkg::tx_data_off)
                tx_req <= 1'b1;
            else if (tx_ack)
                tx_req <= 1'b0; // Phase 3
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && offset == uart_reg_pkg::tx_data_off)
            tx_req_data <= '{word: pwdata, strb: pstrb};
    end

endmodule

`default_nettype wire

/* hdl/line_error_flags.sv */
`timescale 1ns/1ps
`default_nettype none

module line_error_flags (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire uart_link_pkg::line_err_t line_err,
    input  wire [3:0]                     clr_pulse,
    input  wire uart_reg_pkg::bus_word_t  status_word,
    input  wire uart_reg_pkg::bus_word_t  int_en,
    output uart_link_pkg::line_err_t      err_flags,
    output logic                          interrupt
);

    // Sticky until cleared, clear wins over a new event
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            err_flags <= '0;
        end else begin
            if (clr_pulse[uart_reg_pkg::clr_parity])
                err_flags.parity_err <= 1'b0;
            else if (line_err.parity_err)
                err_flags.parity_err <= 1'b1;

            if (clr_pulse[uart_reg_pkg::clr_overrun])
                err_flags.overrun_err <= 1'b0;
            else if (line_err.overrun_err)
                err_flags.overrun_err <= 1'b1;

            if (clr_pulse[uart_reg_pkg::clr_frame])
                err_flags.frame_err <= 1'b0;
            else if (line_err.frame_err)
                err_flags.frame_err <= 1'b1;

            if (clr_pulse[uart_reg_pkg::clr_break])
                err_flags.break_err <= 1'b0;
            else if (line_err.break_err)
                err_flags.break_err <= 1'b1;
        end
    end

    assign interrupt = |(status_word & int_en); // Level, stays up while enabled bit set

endmodule

`default_nettype wire

/* hdl/rx_word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_word_packer (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire                            rx_notempty,
    input  wire uart_link_pkg::uart_byte_t rx_data,
    output logic                           rx_fifo_read_en,
    output uart_reg_pkg::bus_word_t        rx_word
);

    typedef enum logic [1:0] {s_idle, s_receive, s_commit} state_t;

    state_t                  state;
    logic [2:0]              count; // Bytes taken, 0 to 4
    uart_reg_pkg::bus_word_t rx_buf;

    assign rx_fifo_read_en = (state == s_receive) && rx_notempty;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= s_idle;
            count   <= 3'd0;
            rx_word <= '0;
        end else begin
            case (state)
                s_idle: begin
                    count <= 3'd0;
                    if (rx_notempty)
                        state <= s_receive;
                end
                s_receive: begin
                    if (rx_notempty) begin
                        count <= count + 3'd1;
                        if (count == 3'd3)
                            state <= s_commit; // Word full
                    end else begin
                        state <= s_commit;
                    end
                end
                s_commit: begin
                    // Unfilled lanes read as zero
                    for (int k = 0; k < 4; k++) begin
                        rx_word[8*k +: 8] <= (k < int'(count)) ? rx_buf[8*k +: 8] : 8'h00;
                    end
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_fifo_read_en)
            rx_buf[8*count[1:0] +: 8] <= rx_data;
    end

endmodule

`default_nettype wire

/* hdl/tx_word_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_word_unpacker (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         tx_req,
    input  wire uart_reg_pkg::tx_req_t  tx_req_data,
    output logic                        tx_ack,
    input  wire                         tx_notfull,
    output uart_link_pkg::uart_byte_t   tx_data,
    output logic                        tx_fifo_write_en
);

    typedef enum logic [1:0] {s_idle, s_ack, s_send} state_t;

    state_t                  state;
    uart_reg_pkg::bus_word_t word_q;
    uart_reg_pkg::bus_strb_t strb_left; // Lanes still to push
    logic [1:0]              lane;
    logic                    active;

    // Lowest pending lane first
    always_comb begin
        lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (strb_left[i])
                lane = 2'(i);
        end
    end

    assign active           = (state == s_ack) || (state == s_send);
    assign tx_fifo_write_en = active && tx_notfull && (strb_left != 4'b0000);
    assign tx_data          = word_q[8*lane +: 8];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= s_idle;
            tx_ack    <= 1'b0;
            strb_left <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (tx_req) begin
                        strb_left <= tx_req_data.strb;
                        tx_ack    <= 1'b1;
                        state     <= s_ack;
                    end
                end
                s_ack: state <= s_send; // Request drops during this cycle
                s_send: begin
                    if (strb_left == 4'b0000 && !tx_req) begin
                        tx_ack <= 1'b0; // Last byte gone
                        state  <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
            if (tx_fifo_write_en)
                strb_left[lane] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && tx_req)
            word_q <= tx_req_data.word;
    end

endmodule

`default_nettype wire

/* hdl/uart_apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_apb_master #(
    parameter uart_reg_pkg::bus_word_t base_addr = '0
) (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire uart_reg_pkg::bus_word_t     paddr,
    input  wire                              psel,
    input  wire                              penable,
    input  wire                              pwrite,
    input  wire uart_reg_pkg::bus_word_t     pwdata,
    input  wire uart_reg_pkg::bus_strb_t     pstrb,
    output wire                              pready,
    output uart_reg_pkg::bus_word_t          prdata,
    output wire                              pslverr,
    output uart_link_pkg::uart_byte_t        tx_data,
    output wire                              tx_fifo_write_en,
    input  wire uart_link_pkg::uart_byte_t   rx_data,
    output wire                              rx_fifo_read_en,
    input  wire uart_link_pkg::fifo_status_t fifo_status,
    input  wire uart_link_pkg::line_err_t    line_err,
    output uart_link_pkg::line_cfg_t         line_cfg,
    output wire                              interrupt
);

    wire                      tx_req;
    wire                      tx_ack;
    uart_reg_pkg::tx_req_t    tx_req_data;
    uart_reg_pkg::bus_word_t  rx_word;
    uart_reg_pkg::bus_word_t  status_word;
    uart_reg_pkg::bus_word_t  int_en;
    uart_link_pkg::line_err_t err_flags;
    wire [3:0]                clr_pulse;

    apb_reg_file #(.base_addr(base_addr)) i_reg_file (
        .clk, .resetn,
        .paddr, .pwdata, .psel, .penable, .pwrite, .pstrb,
        .pready, .prdata, .pslverr,
        .rx_word, .fifo_status, .err_flags,
        .tx_ack, .tx_req, .tx_req_data,
        .line_cfg, .status_word, .clr_pulse, .int_en
    );

    line_error_flags i_err_flags (
        .clk, .resetn,
        .line_err, .clr_pulse, .status_word, .int_en,
        .err_flags, .interrupt
    );

    tx_word_unpacker i_tx_unpacker (
        .clk, .resetn,
        .tx_req, .tx_req_data, .tx_ack,
        .tx_notfull (fifo_status.tx_notfull),
        .tx_data, .tx_fifo_write_en
    );

    rx_word_packer i_rx_packer (
        .clk, .resetn,
        .rx_notempty (fifo_status.rx_notempty),
        .rx_data, .rx_fifo_read_en, .rx_word
    );

endmodule

`default_nettype wire

/* hdl/uart_link_pkg.sv */
`default_nettype none

package uart_link_pkg;

    typedef logic [7:0] uart_byte_t;

    // parity_mode: 0 none, 1 odd, 2 even
    typedef struct packed {
        logic [31:0] baud;
        logic [1:0]  parity_mode;
        logic [1:0]  stop_bits;
    } line_cfg_t;

    // Same order as status bits 3:0
    typedef struct packed {
        logic tx_done;
        logic tx_notfull;
        logic rx_notfull;
        logic rx_notempty;
    } fifo_status_t;

    // Same order as status bits 7:4 and the clear bits
    typedef struct packed {
        logic break_err;
        logic frame_err;
        logic overrun_err;
        logic parity_err;
    } line_err_t;

endpackage

`default_nettype wire

/* hdl/uart_reg_pkg.sv */
`default_nettype none

package uart_reg_pkg;

    typedef logic [31:0] bus_word_t;
    typedef logic [3:0]  bus_strb_t;

    // Register offsets from the block base
    localparam bus_word_t tx_data_off      = 32'h00; // Write only
    localparam bus_word_t rx_data_off      = 32'h04; // Read only
    localparam bus_word_t baud_off         = 32'h08;
    localparam bus_word_t status_off       = 32'h0C; // Read only
    localparam bus_word_t control_off      = 32'h10;
    localparam bus_word_t status_clear_off = 32'h14; // Write only
    localparam bus_word_t int_en_off       = 32'h18;

    localparam bus_word_t baud_reset    = 32'h0000_0A2C;
    localparam bus_word_t control_reset = 32'h0000_0000;
    localparam bus_word_t int_en_reset  = 32'h0000_0000;

    // Status word layout, upper bits read zero
    localparam int unsigned st_rx_notempty = 0;
    localparam int unsigned st_rx_notfull  = 1;
    localparam int unsigned st_tx_notfull  = 2;
    localparam int unsigned st_tx_done     = 3;
    localparam int unsigned st_parity      = 4;
    localparam int unsigned st_overrun     = 5;
    localparam int unsigned st_frame       = 6;
    localparam int unsigned st_break       = 7;

    // Status clear layout
    localparam int unsigned clr_parity  = 0;
    localparam int unsigned clr_overrun = 1;
    localparam int unsigned clr_frame   = 2;
    localparam int unsigned clr_break   = 3;

    // Word handed from the register file to the TX unpacker
    typedef struct packed {
        bus_word_t word;
        bus_strb_t strb;
    } tx_req_t;

endpackage

`default_nettype wire

/* uart_apb_master.f */
hdl/uart_reg_pkg.sv
hdl/uart_link_pkg.sv
hdl/apb_reg_file.sv
hdl/line_error_flags.sv
hdl/tx_word_unpacker.sv
hdl/rx_word_packer.sv
hdl/uart_apb_master.sv
bench/uart_apb_assertions.sv
bench/tb_uart_apb_master.sv
